// File: hw/dbg_i2c_pkg.sv
// Debug I2C slave shared definitions
// Protocol widths, command byte fields and FSM encodings
`default_nettype none

package dbg_i2c_pkg;

  //======================================================================
  // Protocol widths
  //======================================================================
  localparam int I2C_ADDR_W = 7;  // 7-bit device address
  localparam int DBG_ADDR_W = 6;  // Debug register index
  localparam int DBG_DATA_W = 16; // Debug register word
  localparam int BYTE_W     = 8;
  localparam int SHIFT_W    = 9;  // Byte plus marker bit

  // Command byte fields
  localparam int CMD_WR_BIT = 7;  // 1 = write, 0 = read
  localparam int CMD_BW_BIT = 6;  // 1 = 8-bit access

  typedef logic [I2C_ADDR_W-1:0] i2c_addr_t;
  typedef logic [DBG_ADDR_W-1:0] dbg_addr_t;
  typedef logic [DBG_DATA_W-1:0] dbg_data_t;
  typedef logic [BYTE_W-1:0]     byte_t;

  //======================================================================
  // State and opcode encodings
  //======================================================================
  typedef enum logic [2:0] {
    RX_ADDR,      // Waiting for address byte
    RX_ADDR_ACK,  // Slave ACKs the address
    RX_DATA,
    RX_DATA_ACK,
    TX_DATA,      // Slave shifting out a byte
    TX_DATA_ACK   // Master ACK or NACK
  } i2c_state_e;

  typedef enum logic [2:0] {
    RX_CMD,
    RX_BYTE_LO,
    RX_BYTE_HI,
    TX_BYTE_LO,
    TX_BYTE_HI
  } dbg_state_e;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } dbg_op_e;

endpackage

`default_nettype wire

// File: hw/dbg_i2c_ifs.sv
// Debug I2C slave internal interfaces
// Filtered line events, byte-level handoff and command control pulses
`timescale 1ns/1ps
`default_nettype none

// Filtered SCL/SDA levels and events from the front end
interface i2c_line_if;
  logic sda;        // Filtered SDA
  logic scl_level;  // Filtered SCL
  logic scl_fe;     // SCL fall, one cycle
  logic scl_re;     // SCL rise, one cycle
  logic scl_sample; // scl_re two cycles later
  logic start_det;
  logic stop_det;

  modport source (output sda, scl_level, scl_fe, scl_re, scl_sample, start_det, stop_det);
  modport sink   (input  sda, scl_level, scl_fe, scl_re, scl_sample, start_det, stop_det);
endinterface

// Byte handoff between the engine and the command layer
interface i2c_byte_if;
  logic               rx_done; // Data byte received, address excluded
  logic               tx_done; // Byte fully shifted out
  dbg_i2c_pkg::byte_t rx_byte;
  dbg_i2c_pkg::byte_t tx_byte; // Loaded on SCL rise of ACK bit

  modport engine  (output rx_done, tx_done, rx_byte, input tx_byte);
  modport monitor (input  rx_done, tx_done, rx_byte, tx_byte);
  modport access  (input  rx_byte, output tx_byte);
endinterface

// Command FSM to register access
interface dbg_reg_ctrl_if;
  logic cmd_valid; // Command byte accepted
  logic lo_valid;  // Low data byte accepted
  logic hi_valid;  // High data byte accepted
  logic tx_hi_sel; // Sending high byte
  logic bw;        // 8-bit access

  modport source (output cmd_valid, lo_valid, hi_valid, tx_hi_sel, bw);
  modport sink   (input  cmd_valid, lo_valid, hi_valid, tx_hi_sel, bw);
endinterface

`default_nettype wire

// File: hw/i2c_line_frontend.sv
// I2C line front end
// Synchronizes and majority-filters SCL/SDA, detects edges, START and STOP
`timescale 1ns/1ps
`default_nettype none

module i2c_line_frontend (
  input  logic     dbg_clk,
  input  logic     dbg_rst,
  input  logic     scl_pin,
  input  logic     sda_pin,
  i2c_line_if.source line
);

  // Both pins handled side by side, bit 1 = SCL, bit 0 = SDA
  logic [1:0] sync_q1;
  logic [1:0] sync_q2;
  logic [1:0] hist_q1;
  logic [1:0] hist_q2;
  logic [1:0] filt;
  logic [1:0] filt_q;
  logic [1:0] scl_re_dly;
  logic       scl_re;
  logic       sda_fe;
  logic       sda_re;

  //======================================================================
  // Synchronizer and history
  //======================================================================
  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      sync_q1 <= 2'b11;  // Idle bus is high
      sync_q2 <= 2'b11;
      hist_q1 <= 2'b11;
      hist_q2 <= 2'b11;
    end else begin
      sync_q1 <= {scl_pin, sda_pin};
      sync_q2 <= sync_q1;
      hist_q1 <= sync_q2;
      hist_q2 <= hist_q1;
    end
  end

  // 2 of 3 vote over current sample and history
  assign filt = (sync_q2 & hist_q1) |
                (sync_q2 & hist_q2) |
                (hist_q1 & hist_q2);

  //======================================================================
  // Edge detection
  //======================================================================
  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      filt_q     <= 2'b11;
      scl_re_dly <= 2'b00;
    end else begin
      filt_q     <= filt;
      scl_re_dly <= {scl_re_dly[0], scl_re};  // SDA settles before sampling
    end
  end

  assign scl_re = ~filt_q[1] &  filt[1];
  assign sda_fe =  filt_q[0] & ~filt[0];
  assign sda_re = ~filt_q[0] &  filt[0];

  assign line.sda        = filt[0];
  assign line.scl_level  = filt[1];
  assign line.scl_fe     = filt_q[1] & ~filt[1];
  assign line.scl_re     = scl_re;
  assign line.scl_sample = scl_re_dly[1];

  // SDA moving while SCL high marks a frame boundary
  assign line.start_det  = sda_fe & filt[1];
  assign line.stop_det   = sda_re & filt[1];

endmodule

`default_nettype wire

// File: hw/i2c_byte_engine.sv
// I2C slave byte engine
// Bus tracking, byte FSM, 9-bit shift register, address match and SDA drive
`timescale 1ns/1ps
`default_nettype none

module i2c_byte_engine (
  input  logic                   dbg_clk,
  input  logic                   dbg_rst,
  i2c_line_if.sink               line,
  i2c_byte_if.engine             bytes,
  input  dbg_i2c_pkg::i2c_addr_t slave_addr,
  output logic                   sda_out
);

  dbg_i2c_pkg::i2c_state_e          state_q;
  dbg_i2c_pkg::i2c_state_e          state_d;
  logic [dbg_i2c_pkg::SHIFT_W-1:0]  shift_q;
  logic [dbg_i2c_pkg::SHIFT_W-1:0]  shift_d;
  logic active_q;
  logic active;
  logic bus_init;   // Force FSM and shifter back to idle
  logic addr_miss;
  logic rx_en, tx_en, tx_en_pre;
  logic rx_last, tx_last;
  logic rx_init, tx_init, rx_shift, tx_shift;

  //======================================================================
  // Bus activity
  //======================================================================
  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst)                             active_q <= 1'b0;
    else if (line.start_det)                 active_q <= 1'b1;
    else if (line.stop_det || addr_miss)     active_q <= 1'b0;  // Not us, or frame done
  end

  assign active   = active_q & ~line.stop_det;
  assign bus_init = ~active | line.start_det;

  // Marker bit reaches the top after 8 shifts
  assign rx_last   = rx_en & line.scl_fe & shift_q[dbg_i2c_pkg::SHIFT_W-1];
  assign tx_last   = tx_en & line.scl_fe & (shift_q == {1'b1, dbg_i2c_pkg::byte_t'(0)});
  assign addr_miss = (state_q == dbg_i2c_pkg::RX_ADDR) && rx_last &&
                     (shift_q[dbg_i2c_pkg::BYTE_W-1:1] != slave_addr);

  //======================================================================
  // Byte FSM
  //======================================================================
  always_comb begin
    state_d = state_q;
    if (bus_init) begin
      state_d = dbg_i2c_pkg::RX_ADDR;
    end else begin
      case (state_q)
        dbg_i2c_pkg::RX_ADDR:
          if (rx_last && !addr_miss) state_d = dbg_i2c_pkg::RX_ADDR_ACK;
        dbg_i2c_pkg::RX_ADDR_ACK:  // LSB of address byte is R/W
          if (line.scl_fe) state_d = shift_q[0] ? dbg_i2c_pkg::TX_DATA : dbg_i2c_pkg::RX_DATA;
        dbg_i2c_pkg::RX_DATA:
          if (rx_last) state_d = dbg_i2c_pkg::RX_DATA_ACK;
        dbg_i2c_pkg::RX_DATA_ACK:
          if (line.scl_fe) state_d = dbg_i2c_pkg::RX_DATA;
        dbg_i2c_pkg::TX_DATA:
          if (tx_last) state_d = dbg_i2c_pkg::TX_DATA_ACK;
        dbg_i2c_pkg::TX_DATA_ACK:  // NACK ends the read
          if (line.scl_fe) state_d = line.sda ? dbg_i2c_pkg::RX_ADDR : dbg_i2c_pkg::TX_DATA;
        default: state_d = dbg_i2c_pkg::RX_ADDR;
      endcase
    end
  end

  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) state_q <= dbg_i2c_pkg::RX_ADDR;
    else         state_q <= state_d;
  end

  //======================================================================
  // Shift register
  //======================================================================
  assign rx_en     = (state_q == dbg_i2c_pkg::RX_ADDR) || (state_q == dbg_i2c_pkg::RX_DATA) ||
                     (state_q == dbg_i2c_pkg::RX_DATA_ACK);
  assign tx_en     = (state_q == dbg_i2c_pkg::TX_DATA) || (state_q == dbg_i2c_pkg::TX_DATA_ACK);
  assign tx_en_pre = (state_d == dbg_i2c_pkg::TX_DATA) || (state_d == dbg_i2c_pkg::TX_DATA_ACK);

  assign rx_init  = bus_init ||
                    ((state_q == dbg_i2c_pkg::RX_ADDR_ACK) && line.scl_fe && !shift_q[0]) ||
                    ((state_q == dbg_i2c_pkg::RX_DATA_ACK) && line.scl_fe);
  assign tx_init  = ((state_q == dbg_i2c_pkg::RX_ADDR_ACK) && line.scl_re && shift_q[0]) ||
                    ((state_q == dbg_i2c_pkg::TX_DATA_ACK) && line.scl_re);
  assign rx_shift = rx_en && line.scl_sample && line.scl_level;  // Drop if SCL already fell
  assign tx_shift = tx_en_pre && line.scl_fe && (shift_q != {1'b1, dbg_i2c_pkg::byte_t'(0)});

  always_comb begin
    if (rx_init)       shift_d = {dbg_i2c_pkg::byte_t'(0), 1'b1};     // Marker at bit 0
    else if (tx_init)  shift_d = {bytes.tx_byte, 1'b1};
    else if (rx_shift) shift_d = {shift_q[dbg_i2c_pkg::BYTE_W-1:0], line.sda};
    else if (tx_shift) shift_d = {shift_q[dbg_i2c_pkg::BYTE_W-1:0], 1'b0};
    else               shift_d = shift_q;
  end

  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) shift_q <= {dbg_i2c_pkg::byte_t'(0), 1'b1};
    else         shift_q <= shift_d;
  end

  //======================================================================
  // SDA drive, changes only on SCL fall
  //======================================================================
  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      sda_out <= 1'b1;  // Released
    end else if (line.scl_fe) begin
      sda_out <= ~((state_d == dbg_i2c_pkg::RX_ADDR_ACK) ||
                   (state_d == dbg_i2c_pkg::RX_DATA_ACK) ||
                   (tx_shift && !shift_q[dbg_i2c_pkg::SHIFT_W-1]));  // MSB first
    end
  end

  assign bytes.rx_done = rx_last && (state_q == dbg_i2c_pkg::RX_DATA);
  assign bytes.tx_done = tx_last;
  assign bytes.rx_byte = shift_q[dbg_i2c_pkg::BYTE_W-1:0];

endmodule

`default_nettype wire

// File: hw/dbg_cmd_ctrl.sv
// Debug command controller
// Sequences command, low byte and high byte for register reads and writes
`timescale 1ns/1ps
`default_nettype none

module dbg_cmd_ctrl (
  input  logic           dbg_clk,
  input  logic           dbg_rst,
  i2c_byte_if.monitor    bytes,
  dbg_reg_ctrl_if.source ctrl
);

  dbg_i2c_pkg::dbg_state_e state_q;
  dbg_i2c_pkg::dbg_state_e state_d;
  dbg_i2c_pkg::dbg_op_e    op;       // Decoded from incoming command byte
  logic                    bw_q;

  assign op = bytes.rx_byte[dbg_i2c_pkg::CMD_WR_BIT] ? dbg_i2c_pkg::OP_WRITE
                                                     : dbg_i2c_pkg::OP_READ;

  //======================================================================
  // Command FSM
  //======================================================================
  always_comb begin
    state_d = state_q;
    case (state_q)
      dbg_i2c_pkg::RX_CMD:
        if (bytes.rx_done)
          state_d = (op == dbg_i2c_pkg::OP_WRITE) ? dbg_i2c_pkg::RX_BYTE_LO
                                                  : dbg_i2c_pkg::TX_BYTE_LO;
      dbg_i2c_pkg::RX_BYTE_LO:  // 8-bit write ends here
        if (bytes.rx_done) state_d = bw_q ? dbg_i2c_pkg::RX_CMD : dbg_i2c_pkg::RX_BYTE_HI;
      dbg_i2c_pkg::RX_BYTE_HI:
        if (bytes.rx_done) state_d = dbg_i2c_pkg::RX_CMD;
      dbg_i2c_pkg::TX_BYTE_LO:
        if (bytes.tx_done) state_d = bw_q ? dbg_i2c_pkg::RX_CMD : dbg_i2c_pkg::TX_BYTE_HI;
      dbg_i2c_pkg::TX_BYTE_HI:
        if (bytes.tx_done) state_d = dbg_i2c_pkg::RX_CMD;
      default: state_d = dbg_i2c_pkg::RX_CMD;
    endcase
  end

  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) state_q <= dbg_i2c_pkg::RX_CMD;
    else         state_q <= state_d;
  end

  // Width flag held for the whole access
  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      bw_q <= 1'b0;
    end else if (ctrl.cmd_valid) begin
      bw_q <= bytes.rx_byte[dbg_i2c_pkg::CMD_BW_BIT];
    end
  end

  //======================================================================
  // Pulses toward register access
  //======================================================================
  assign ctrl.cmd_valid = (state_q == dbg_i2c_pkg::RX_CMD)     && bytes.rx_done;
  assign ctrl.lo_valid  = (state_q == dbg_i2c_pkg::RX_BYTE_LO) && bytes.rx_done;
  assign ctrl.hi_valid  = (state_q == dbg_i2c_pkg::RX_BYTE_HI) && bytes.rx_done;
  assign ctrl.tx_hi_sel = (state_q == dbg_i2c_pkg::TX_BYTE_HI);
  assign ctrl.bw        = bw_q;

endmodule

`default_nettype wire

// File: hw/dbg_reg_access.sv
// Debug register access
// Address and write data latches, write/read strobes, transmit byte select
`timescale 1ns/1ps
`default_nettype none

module dbg_reg_access (
  input  logic                   dbg_clk,
  input  logic                   dbg_rst,
  i2c_byte_if.access             bytes,
  dbg_reg_ctrl_if.sink           ctrl,
  input  dbg_i2c_pkg::dbg_data_t dbg_dout,
  output dbg_i2c_pkg::dbg_addr_t dbg_addr,
  output dbg_i2c_pkg::dbg_data_t dbg_din,
  output logic                   dbg_wr,
  output logic                   dbg_rd
);

  dbg_i2c_pkg::byte_t din_lo_q;
  dbg_i2c_pkg::byte_t din_hi_q;

  //======================================================================
  // Address and data latches
  //======================================================================
  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst)             dbg_addr <= '0;
    else if (ctrl.cmd_valid) dbg_addr <= bytes.rx_byte[dbg_i2c_pkg::DBG_ADDR_W-1:0];
  end

  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      din_lo_q <= '0;
      din_hi_q <= '0;
    end else if (ctrl.lo_valid) begin
      din_lo_q <= bytes.rx_byte;
      din_hi_q <= '0;               // Zero for 8-bit writes
    end else if (ctrl.hi_valid) begin
      din_hi_q <= bytes.rx_byte;
    end
  end

  assign dbg_din = {din_hi_q, din_lo_q};

  //======================================================================
  // Strobes, one cycle each
  //======================================================================
  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      dbg_wr <= 1'b0;
      dbg_rd <= 1'b0;
    end else begin
      dbg_wr <= ctrl.bw ? ctrl.lo_valid : ctrl.hi_valid;  // After last data byte
      dbg_rd <= ctrl.cmd_valid && !bytes.rx_byte[dbg_i2c_pkg::CMD_WR_BIT];
    end
  end

  // Read data goes out low byte first
  assign bytes.tx_byte = ctrl.tx_hi_sel ? dbg_dout[dbg_i2c_pkg::DBG_DATA_W-1:dbg_i2c_pkg::BYTE_W]
                                        : dbg_dout[dbg_i2c_pkg::BYTE_W-1:0];

endmodule

`default_nettype wire

// File: hw/dbg_i2c_top.sv
// Debug I2C slave top level
// Front end, byte engine, command FSM and register access
`timescale 1ns/1ps
`default_nettype none

module dbg_i2c_top (
  input  logic                   dbg_clk,
  input  logic                   dbg_rst,
  input  logic                   dbg_i2c_scl,
  input  logic                   dbg_i2c_sda_in,
  input  dbg_i2c_pkg::i2c_addr_t dbg_i2c_addr,    // Our device address
  input  dbg_i2c_pkg::dbg_data_t dbg_dout,        // Register read data
  output logic                   dbg_i2c_sda_out, // Open-drain drive, 1 = release
  output dbg_i2c_pkg::dbg_addr_t dbg_addr,
  output dbg_i2c_pkg::dbg_data_t dbg_din,
  output logic                   dbg_wr,
  output logic                   dbg_rd
);

  i2c_line_if     line_if ();
  i2c_byte_if     byte_if ();
  dbg_reg_ctrl_if ctrl_if ();

  //======================================================================
  // I2C side
  //======================================================================
  i2c_line_frontend u_frontend (
    .dbg_clk (dbg_clk),
    .dbg_rst (dbg_rst),
    .scl_pin (dbg_i2c_scl),
    .sda_pin (dbg_i2c_sda_in),
    .line    (line_if.source)
  );

  i2c_byte_engine u_engine (
    .dbg_clk    (dbg_clk),
    .dbg_rst    (dbg_rst),
    .line       (line_if.sink),
    .bytes      (byte_if.engine),
    .slave_addr (dbg_i2c_addr),
    .sda_out    (dbg_i2c_sda_out)
  );

  //======================================================================
  // Debug register side
  //======================================================================
  dbg_cmd_ctrl u_cmd_ctrl (
    .dbg_clk (dbg_clk),
    .dbg_rst (dbg_rst),
    .bytes   (byte_if.monitor),
    .ctrl    (ctrl_if.source)
  );

  dbg_reg_access u_reg_access (
    .dbg_clk  (dbg_clk),
    .dbg_rst  (dbg_rst),
    .bytes    (byte_if.access),
    .ctrl     (ctrl_if.sink),
    .dbg_dout (dbg_dout),
    .dbg_addr (dbg_addr),
    .dbg_din  (dbg_din),
    .dbg_wr   (dbg_wr),
    .dbg_rd   (dbg_rd)
  );

endmodule

`default_nettype wire

// File: verif/dbg_i2c_properties.sv
// Debug I2C slave port assertions
// Strobe exclusivity and width, SDA change timing
`timescale 1ns/1ps
`default_nettype none

module dbg_i2c_properties (
  input logic dbg_clk,
  input logic dbg_rst,
  input logic dbg_wr,
  input logic dbg_rd,
  input logic dbg_i2c_sda_out,
  input logic scl_fe    // Filtered SCL fall
);

  // Never both strobes
  assert property (@(posedge dbg_clk) disable iff (dbg_rst) !(dbg_wr && dbg_rd))
    else $error("dbg_wr and dbg_rd high together");

  assert property (@(posedge dbg_clk) disable iff (dbg_rst) dbg_wr |=> !dbg_wr)
    else $error("dbg_wr longer than one cycle");

  assert property (@(posedge dbg_clk) disable iff (dbg_rst) dbg_rd |=> !dbg_rd)
    else $error("dbg_rd longer than one cycle");

  // SDA only moves right after SCL falls
  assert property (@(posedge dbg_clk) disable iff (dbg_rst)
                   (dbg_i2c_sda_out != $past(dbg_i2c_sda_out)) |-> $past(scl_fe))
    else $error("dbg_i2c_sda_out changed outside SCL low phase start");

endmodule

bind dbg_i2c_top dbg_i2c_properties u_props (
  .dbg_clk         (dbg_clk),
  .dbg_rst         (dbg_rst),
  .dbg_wr          (dbg_wr),
  .dbg_rd          (dbg_rd),
  .dbg_i2c_sda_out (dbg_i2c_sda_out),
  .scl_fe          (line_if.scl_fe)
);

`default_nettype wire

// File: verif/tb_dbg_i2c.sv
// Debug I2C slave testbench
// Bit-level I2C master, debug register bank model, vector-driven checks
`timescale 1ns/1ps
`default_nettype none

module tb_dbg_i2c;

  localparam int QTR           = 8;            // Quarter SCL period, dbg_clk cycles
  localparam int SCL_PERIOD_NS = 4 * QTR * 4;  // 4 quarters of 4 ns cycles
  localparam int MAX_TXN       = 32;
  localparam int FIELDS        = 5;            // op, addr, cmd, data, ack

  logic                   dbg_clk;
  logic                   dbg_rst;
  logic                   scl;
  logic                   sda_drv;  // Master side of the open-drain line
  logic                   sda_line;
  logic                   sda_out;
  logic                   dbg_wr;
  logic                   dbg_rd;
  dbg_i2c_pkg::i2c_addr_t dev_addr;
  dbg_i2c_pkg::dbg_data_t dbg_dout;
  dbg_i2c_pkg::dbg_data_t dbg_din;
  dbg_i2c_pkg::dbg_addr_t dbg_addr;

  dbg_i2c_pkg::dbg_data_t bank [64];                 // Register bank model
  logic [15:0]            vec_mem [FIELDS*MAX_TXN];
  int                     n_txn;
  int                     wr_count;
  int                     rd_count;
  dbg_i2c_pkg::dbg_addr_t wr_addr;
  dbg_i2c_pkg::dbg_addr_t rd_addr;
  dbg_i2c_pkg::dbg_data_t wr_data;

  assign sda_line = sda_drv & sda_out;  // Wired AND
  assign dbg_dout = bank[dbg_addr];

  dbg_i2c_top dut (
    .dbg_clk         (dbg_clk),
    .dbg_rst         (dbg_rst),
    .dbg_i2c_scl     (scl),
    .dbg_i2c_sda_in  (sda_line),
    .dbg_i2c_addr    (dev_addr),
    .dbg_dout        (dbg_dout),
    .dbg_i2c_sda_out (sda_out),
    .dbg_addr        (dbg_addr),
    .dbg_din         (dbg_din),
    .dbg_wr          (dbg_wr),
    .dbg_rd          (dbg_rd)
  );

  always #2 dbg_clk = ~dbg_clk;

  // Strobe monitor, bank write on dbg_wr
  always @(posedge dbg_clk) begin
    if (dbg_wr) begin
      wr_count++;
      wr_addr = dbg_addr;
      wr_data = dbg_din;
      bank[dbg_addr] = dbg_din;
    end
    if (dbg_rd) begin
      rd_count++;
      rd_addr = dbg_addr;
    end
  end

  //======================================================================
  // Compare tasks
  //======================================================================
  task automatic abort_run();
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_addr(string name, dbg_i2c_pkg::dbg_addr_t got, dbg_i2c_pkg::dbg_addr_t exp);
    if (got !== exp) begin
      $display("error: %0t %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_data(string name, dbg_i2c_pkg::dbg_data_t got, dbg_i2c_pkg::dbg_data_t exp);
    if (got !== exp) begin
      $display("error: %0t %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("error: %0t %s got %b expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_byte(string name, dbg_i2c_pkg::byte_t got, dbg_i2c_pkg::byte_t exp);
    if (got !== exp) begin
      $display("error: %0t %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_count(string name, int got, int exp);
    if (got != exp) begin
      $display("error: %0t %s pulses got %0d expected %0d", $time, name, got, exp);
      abort_run();
    end
  endtask

  //======================================================================
  // I2C master
  //======================================================================
  task automatic wait_cycles(int n);
    repeat (n) @(posedge dbg_clk);
    #0.5;  // Drive off the edge
  endtask

  task automatic bus_start();  // Also a repeated START from SCL low
    wait_cycles(QTR);
    sda_drv = 1'b1;
    wait_cycles(QTR);
    scl = 1'b1;
    wait_cycles(QTR);
    sda_drv = 1'b0;  // SDA falls with SCL high
    wait_cycles(QTR);
    scl = 1'b0;
  endtask

  task automatic bus_stop();
    wait_cycles(QTR);
    sda_drv = 1'b0;
    wait_cycles(QTR);
    scl = 1'b1;
    wait_cycles(QTR);
    sda_drv = 1'b1;  // SDA rises with SCL high
    wait_cycles(2 * QTR);
  endtask

  task automatic send_bit(logic b);
    wait_cycles(QTR);
    sda_drv = b;
    wait_cycles(QTR);
    scl = 1'b1;
    wait_cycles(2 * QTR);
    scl = 1'b0;
  endtask

  task automatic recv_bit(output logic b);
    wait_cycles(QTR);
    sda_drv = 1'b1;  // Release for the slave
    wait_cycles(QTR);
    scl = 1'b1;
    wait_cycles(QTR);
    b = sda_line;    // Mid high phase
    wait_cycles(QTR);
    scl = 1'b0;
  endtask

  task automatic send_byte(dbg_i2c_pkg::byte_t data, output logic ack);
    for (int i = 7; i >= 0; i--) send_bit(data[i]);  // MSB first
    recv_bit(ack);
  endtask

  task automatic recv_byte(output dbg_i2c_pkg::byte_t data, input logic nack);
    logic b;
    for (int i = 7; i >= 0; i--) begin
      recv_bit(b);
      data[i] = b;
    end
    send_bit(nack);  // 1 ends the read
  endtask

  //======================================================================
  // One vector line
  //======================================================================
  task automatic run_txn(int idx);
    int                     base;
    logic [1:0]             op;
    dbg_i2c_pkg::i2c_addr_t a;
    dbg_i2c_pkg::byte_t     cmd;
    dbg_i2c_pkg::dbg_data_t data;
    dbg_i2c_pkg::byte_t     rx;
    logic                   exp_ack;
    logic                   ack;
    logic                   bw;
    base    = FIELDS * idx;
    op      = vec_mem[base][1:0];
    a       = vec_mem[base+1][6:0];
    cmd     = vec_mem[base+2][7:0];
    data    = vec_mem[base+3];
    exp_ack = vec_mem[base+4][0];
    cmd[dbg_i2c_pkg::CMD_WR_BIT] = (op == 2'd1);  // Direction bit set by the op column
    bw      = cmd[dbg_i2c_pkg::CMD_BW_BIT];
    wr_count = 0;
    rd_count = 0;
    bus_start();
    send_byte({a, 1'b0}, ack);
    check_bit("address ack", ack, exp_ack);
    if (exp_ack) begin          // Not our address, frame dropped
      bus_stop();
      check_count("dbg_wr", wr_count, 0);
      check_count("dbg_rd", rd_count, 0);
    end else if (op == 2'd1) begin
      send_byte(cmd, ack);
      check_bit("command ack", ack, 1'b0);
      send_byte(data[7:0], ack);
      check_bit("low byte ack", ack, 1'b0);
      if (!bw) begin
        send_byte(data[15:8], ack);
        check_bit("high byte ack", ack, 1'b0);
      end
      bus_stop();
      check_count("dbg_wr", wr_count, 1);
      check_count("dbg_rd", rd_count, 0);
      check_addr("dbg_addr", wr_addr, cmd[5:0]);
      check_data("dbg_din", wr_data, bw ? {8'h00, data[7:0]} : data);
    end else begin
      send_byte(cmd, ack);
      check_bit("command ack", ack, 1'b0);
      bus_start();                // Repeated START, read direction
      send_byte({a, 1'b1}, ack);
      check_bit("read address ack", ack, 1'b0);
      recv_byte(rx, bw);          // NACK here if 8-bit
      check_byte("read low byte", rx, data[7:0]);
      if (!bw) begin
        recv_byte(rx, 1'b1);
        check_byte("read high byte", rx, data[15:8]);
      end
      bus_stop();
      check_count("dbg_rd", rd_count, 1);
      check_count("dbg_wr", wr_count, 0);
      check_addr("dbg_addr", rd_addr, cmd[5:0]);
    end
  endtask

  //======================================================================
  // Main sequence
  //======================================================================
  initial begin
    int count;
    void'($urandom(34));
    dbg_clk  = 1'b0;
    dbg_rst  = 1'b1;
    scl      = 1'b1;  // Idle bus
    sda_drv  = 1'b1;
    dev_addr = 7'h50;
    wr_count = 0;
    rd_count = 0;
    n_txn    = 0;
    for (int i = 0; i < 64; i++) bank[i] = {2'b11, 6'(i), 2'b00, 6'(i)};  // Address pattern
    for (int i = 0; i < FIELDS * MAX_TXN; i++) vec_mem[i] = 16'h0000;
    $readmemh("verif/dbg_i2c_vectors.txt", vec_mem);
    count = 0;
    while (count < MAX_TXN && (vec_mem[FIELDS*count] == 16'd1 || vec_mem[FIELDS*count] == 16'd2))
      count++;
    n_txn = count;
    repeat (2) @(posedge dbg_clk);
    #0.5;
    dbg_rst = 1'b0;
    wait_cycles(4);
    check_bit("dbg_i2c_sda_out", sda_out, 1'b1);
    check_bit("dbg_wr", dbg_wr, 1'b0);
    check_bit("dbg_rd", dbg_rd, 1'b0);
    check_addr("dbg_addr", dbg_addr, '0);
    check_data("dbg_din", dbg_din, '0);
    for (int t = 0; t < n_txn; t++) begin
      run_txn(t);
      wait_cycles(8 + int'($urandom % 24));  // Idle gap
    end
    if (n_txn == 0) begin
      $display("no transactions found in the vector file");
      abort_run();
    end else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

  // Watchdog sized from the vector count
  initial begin
    wait (n_txn > 0);
    #(longint'(n_txn) * 40 * SCL_PERIOD_NS * 2);
    $display("watchdog expired before the last transaction finished");
    abort_run();
  end

endmodule

`default_nettype wire

// File: verif/dbg_i2c_vectors.txt
// op (1 write, 2 read) | device addr | command byte | data (read: expected) | addr ack (1 = NACK)
// command bit 7 write, bit 6 8-bit access, bits 5:0 register
1 50 85 1234 0
2 50 05 1234 0
1 50 4A 00BE 0
2 50 4A 00BE 0
1 51 85 FFFF 1
2 50 05 1234 0
1 50 BF CAFE 0
1 50 C5 0077 0
2 50 05 0077 0
2 50 3F CAFE 0
1 2A 80 0000 1
1 50 80 A55A 0
2 50 40 005A 0
2 50 00 A55A 0
2 33 05 0000 1
1 50 D2 00F0 0
2 50 12 00F0 0
1 50 92 8001 0
2 50 52 0001 0
2 50 12 8001 0

// File: files.f
hw/dbg_i2c_pkg.sv
hw/dbg_i2c_ifs.sv
hw/i2c_line_frontend.sv
hw/i2c_byte_engine.sv
hw/dbg_cmd_ctrl.sv
hw/dbg_reg_access.sv
hw/dbg_i2c_top.sv
verif/dbg_i2c_properties.sv
verif/tb_dbg_i2c.sv

// File: Makefile
# Verilator build and run of the debug I2C slave testbench

VERILATOR ?= verilator
TOP       ?= tb_dbg_i2c
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
